/* vlog.f */
rvdec_pkg.sv
rvdec_imm_gen.sv
rvdec_func_map.sv
rvdec_op_decode.sv
rvdec_skid_buffer.sv
rvdec_top.sv
tb_clkgen.sv
tb_rvdec.sv

/* Bender.yml */
package:
  name: rvdec

sources:
  - rvdec_pkg.sv
  - rvdec_imm_gen.sv
  - rvdec_func_map.sv
  - rvdec_op_decode.sv
  - rvdec_skid_buffer.sv
  - rvdec_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_rvdec.sv

/* tb_rvdec.sv */
// Testbench for the decode stage with LFSR stimulus, reference decoder and checker
`default_nettype none

module tb_rvdec;
    timeunit 1ns;
    timeprecision 1ps;
    import rvdec_pkg::*;

    localparam int N_INSTR     = 40 + 20 + 40 + 22 + 60;
    localparam int CYCLE_LIMIT = 4 * N_INSTR + 200;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_t      fetch;
    logic        decode_valid;
    logic        decode_ready;
    decode_t     decode;
    sched_t      sched;

    logic [31:0] lfsr;
    decode_t     exp_q [$];
    logic        ready_drops;
    int          cycles;
    int          err_cnt;
    int          err_mark;
    int          tests_ok;
    int          tests_bad;
    logic [15:0] next_uuid;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rvdec_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch        (fetch),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode       (decode),
        .sched        (sched)
    );

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_instr(input logic [6:0] opc, input logic [2:0] f3);
        logic [31:0] ins;
        ins = rand_bits(32);
        ins[6:0] = opc;
        ins[14:12] = f3;
        if (rand_bits(2) == 0) ins[11:7] = 5'd0; // Some writes aim at x0
        return ins;
    endfunction

    function automatic op_args_u alu_arg(input alu_xtype_e xt, input logic pc,
                                         input logic imm_on, input logic [31:0] imm_v);
        op_args_u a;
        a = '0;
        a.alu.xtype = xt;
        a.alu.use_pc = pc;
        a.alu.use_imm = imm_on;
        a.alu.imm = imm_v;
        return a;
    endfunction

    function automatic decode_t rvdec_model(input fetch_t f, output logic stall);
        decode_t     d;
        logic [31:0] ins;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        use_rd;
        d = '0;
        stall = 1'b0;
        use_rd = 1'b0;
        ins = f.instr;
        opc = ins[6:0];
        f3 = ins[14:12];
        rd = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (f3)
                3'd0: d.fields.op_type = (opc == OPC_OP && ins[30]) ? SUB : ADD;
                3'd1: d.fields.op_type = SLL;
                3'd2: d.fields.op_type = SLT;
                3'd3: d.fields.op_type = SLTU;
                3'd4: d.fields.op_type = XOR;
                3'd5: d.fields.op_type = ins[30] ? SRA : SRL;
                3'd6: d.fields.op_type = OR;
                default: d.fields.op_type = AND;
            endcase
            use_rd = 1'b1;
            d.fields.rs1 = rs1;
            if (opc == OPC_OP) begin
                d.fields.rs2 = rs2;
                d.fields.op_args = alu_arg(ARITH, 1'b0, 1'b0, 32'd0);
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                d.fields.op_args = alu_arg(ARITH, 1'b0, 1'b1, {27'd0, ins[24:20]});
            end else begin
                d.fields.op_args = alu_arg(ARITH, 1'b0, 1'b1, {{20{ins[31]}}, ins[31:20]});
            end
        end else if (opc == OPC_LUI || opc == OPC_AUIPC) begin
            d.fields.op_type = (opc == OPC_LUI) ? LUI : AUIPC;
            d.fields.op_args = alu_arg(ARITH, opc == OPC_AUIPC, 1'b1, {ins[31:12], 12'd0});
            use_rd = 1'b1;
        end else if (opc == OPC_JAL) begin
            d.fields.op_type = JAL;
            d.fields.op_args = alu_arg(BRANCH, 1'b1, 1'b1,
                {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
            use_rd = 1'b1;
            stall = 1'b1;
        end else if (opc == OPC_JALR) begin
            d.fields.op_type = JALR;
            d.fields.op_args = alu_arg(BRANCH, 1'b0, 1'b1, {{20{ins[31]}}, ins[31:20]});
            d.fields.rs1 = rs1;
            use_rd = 1'b1;
            stall = 1'b1;
        end else if (opc == OPC_BRANCH) begin
            case (f3)
                3'd1: d.fields.op_type = NE;
                3'd4: d.fields.op_type = LT;
                3'd5: d.fields.op_type = GE;
                3'd6: d.fields.op_type = LTU;
                3'd7: d.fields.op_type = GEU;
                default: d.fields.op_type = EQ;
            endcase
            d.fields.op_args = alu_arg(BRANCH, 1'b1, 1'b1,
                {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
            d.fields.rs1 = rs1;
            d.fields.rs2 = rs2;
            stall = 1'b1;
        end else if (opc == OPC_LOAD || opc == OPC_STORE) begin
            d.fields.ex_type = EX_LSU;
            d.fields.op_type = {opc == OPC_STORE, f3};
            d.fields.rs1 = rs1;
            if (opc == OPC_STORE) begin
                d.fields.op_args.lsu.is_store = 1'b1;
                d.fields.op_args.lsu.offset = {ins[31:25], ins[11:7]};
                d.fields.rs2 = rs2;
            end else begin
                d.fields.op_args.lsu.offset = ins[31:20];
                use_rd = 1'b1;
            end
        end else if (opc == OPC_FENCE) begin
            d.fields.ex_type = EX_LSU;
        end else if (opc == OPC_SYSTEM) begin
            use_rd = 1'b1;
            if (f3[1:0] != 2'd0) begin
                d.fields.ex_type = EX_SFU;
                d.fields.op_type = (f3[1:0] == 2'd1) ? CSRRW : (f3[1:0] == 2'd2) ? CSRRS : CSRRC;
                d.fields.op_args.csr.addr = ins[31:20];
                d.fields.op_args.csr.use_imm = f3[2];
                if (f3[2]) d.fields.op_args.csr.imm = rs1;
                else d.fields.rs1 = rs1;
            end else begin
                case (ins[31:20])
                    12'h001: d.fields.op_type = EBREAK;
                    12'h002: d.fields.op_type = URET;
                    12'h102: d.fields.op_type = SRET;
                    12'h302: d.fields.op_type = MRET;
                    default: d.fields.op_type = ECALL;
                endcase
                d.fields.op_args = alu_arg(BRANCH, 1'b1, 1'b1, 32'd4); // Link is PC + 4
                stall = 1'b1;
            end
        end else if (opc == OPC_EXT1 && ins[31:25] == 7'd0 && f3 <= 3'd5) begin
            d.fields.ex_type = EX_SFU;
            d.fields.rs1 = rs1;
            stall = 1'b1;
            case (f3)
                3'd0: d.fields.op_type = TMC;
                3'd1: d.fields.op_type = WSPAWN;
                3'd2: d.fields.op_type = SPLIT;
                3'd3: d.fields.op_type = JOIN;
                3'd4: d.fields.op_type = BAR;
                default: d.fields.op_type = PRED;
            endcase
            if (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd5) d.fields.rs2 = rs2;
            if (f3 == 3'd2) begin
                d.fields.op_args.wctl.is_neg = rs2[0];
                use_rd = 1'b1;
            end
            if (f3 == 3'd5) d.fields.op_args.wctl.is_neg = rd[0];
        end
        if (use_rd) d.fields.rd = rd;
        d.fields.wb = use_rd && (rd != 5'd0);
        d.uuid = f.uuid;
        d.wid = f.wid;
        d.tmask = f.tmask;
        d.pc = f.pc;
        return d;
    endfunction

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR %0d ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (ready_drops) decode_ready = (rand_bits(2) != 0);
    endtask

    task automatic send(input logic [31:0] instr);
        fetch.uuid = next_uuid;
        fetch.wid = WID_W'(rand_bits(WID_W));
        fetch.tmask = NUM_THREADS'(rand_bits(NUM_THREADS));
        fetch.pc = rand_bits(30) << 2;
        fetch.instr = instr;
        fetch_valid = 1'b1;
        next_uuid++;
        while (!fetch_ready) next_cycle(); // Held stable until accepted
        next_cycle();
    endtask

    task automatic idle(input int n);
        fetch_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic drain();
        fetch_valid = 1'b0;
        ready_drops = 1'b0;
        decode_ready = 1'b1;
        while (exp_q.size() != 0) next_cycle();
        next_cycle();
    endtask

    task automatic begin_test();
        err_mark = err_cnt;
    endtask

    task automatic end_test(input string name);
        drain();
        if (err_cnt == err_mark) begin
            tests_ok++;
            $display("Test %s: pass", name);
        end else begin
            tests_bad++;
            $display("Test %s: FAIL with %0d mismatches", name, err_cnt - err_mark);
        end
    endtask

    // Compare process sampling on the rising edge
    always @(posedge clk) begin : compare
        decode_t exp_d;
        logic    stall;
        int      held;
        if (rst_n) begin
            held = exp_q.size(); // Entries the buffer should hold now
            check("fetch_ready", fetch_ready, held < 2);
            check("decode_valid", decode_valid, held != 0);
            check("sched.valid", sched.valid, fetch_valid && held < 2);
            if (decode_valid && decode_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Decode output uuid %h appeared with no instruction pending",
                             decode.uuid);
                    err_cnt++;
                end else begin
                    exp_d = exp_q.pop_front();
                    check("decode tag", {decode.uuid, decode.wid, decode.tmask, decode.pc},
                          {exp_d.uuid, exp_d.wid, exp_d.tmask, exp_d.pc});
                    check("decode fields", decode.fields, exp_d.fields);
                end
            end
            if (fetch_valid && fetch_ready) begin
                exp_d = rvdec_model(fetch, stall);
                exp_q.push_back(exp_d);
                check("sched", {sched.wid, sched.is_wstall}, {fetch.wid, stall});
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles with %0d results pending",
                     cycles, exp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] ins;
        logic [6:0]  opc;
        fetch_valid = 1'b0;
        fetch = '0;
        decode_ready = 1'b1;
        ready_drops = 1'b0;
        lfsr = 32'h7915_b07a;
        cycles = 0;
        err_cnt = 0;
        tests_ok = 0;
        tests_bad = 0;
        next_uuid = 16'h0100;
        @(posedge rst_n);
        @(posedge clk);
        @(negedge clk);

        begin_test();
        repeat (4) begin
            check("fetch_ready after reset", fetch_ready, 1'b1);
            check("decode_valid after reset", decode_valid, 1'b0);
            check("sched.valid after reset", sched.valid, 1'b0);
            next_cycle();
        end
        end_test("1 reset state");

        begin_test();
        repeat (40) begin
            opc = rand_bits(1) ? OPC_OP : OPC_OP_IMM;
            ins = rand_instr(opc, 3'(rand_bits(3)));
            if (opc == OPC_OP || ins[13:12] == 2'b01) ins[31:25] = 7'(rand_bits(1) << 5);
            send(ins);
        end
        end_test("2 integer ALU");

        begin_test();
        repeat (2) begin
            send(rand_instr(OPC_LUI, 3'(rand_bits(3))));
            send(rand_instr(OPC_AUIPC, 3'(rand_bits(3))));
            send(rand_instr(OPC_JAL, 3'(rand_bits(3))));
            send(rand_instr(OPC_JALR, 3'd0));
            for (int k = 0; k < 8; k++) begin
                if (k != 2 && k != 3) send(rand_instr(OPC_BRANCH, 3'(k)));
            end
        end
        end_test("3 upper immediates and control flow");

        begin_test();
        repeat (2) begin
            for (int k = 0; k < 6; k++) begin
                if (k != 3) send(rand_instr(OPC_LOAD, 3'(k)));
            end
            for (int k = 0; k < 3; k++) send(rand_instr(OPC_STORE, 3'(k)));
            send(rand_instr(OPC_FENCE, 3'd0));
            for (int k = 1; k < 8; k++) begin
                if (k != 4) send(rand_instr(OPC_SYSTEM, 3'(k)));
            end
            send({12'h000, 13'd0, OPC_SYSTEM});
            send({12'h001, 13'd0, OPC_SYSTEM});
            send({12'h002, 13'd0, OPC_SYSTEM});
            send({12'h102, 13'd0, OPC_SYSTEM});
            send({12'h302, 13'd0, OPC_SYSTEM});
        end
        end_test("4 memory, CSR and system");

        begin_test();
        repeat (2) begin
            for (int k = 0; k < 8; k++) begin
                ins = rand_instr(OPC_EXT1, 3'(k));
                ins[31:25] = 7'd0;
                send(ins);
            end
        end
        ins = rand_instr(OPC_EXT1, 3'd0);
        ins[31:25] = 7'h01; // Not a warp-control encoding
        send(ins);
        send(rand_instr(7'h7f, 3'(rand_bits(3))));
        send(rand_instr(7'h2b, 3'(rand_bits(3))));
        send(rand_instr(7'h53, 3'(rand_bits(3))));
        send(rand_instr(7'h1b, 3'(rand_bits(3))));
        send(rand_instr(7'h3b, 3'(rand_bits(3))));
        end_test("5 warp control and unknown");

        begin_test();
        ready_drops = 1'b1;
        repeat (60) begin
            case (rand_bits(4))
                0: opc = OPC_OP;
                1: opc = OPC_OP_IMM;
                2: opc = OPC_LUI;
                3: opc = OPC_AUIPC;
                4: opc = OPC_JAL;
                5: opc = OPC_JALR;
                6: opc = OPC_BRANCH;
                7: opc = OPC_LOAD;
                8: opc = OPC_STORE;
                9: opc = OPC_FENCE;
                10: opc = OPC_SYSTEM;
                11: opc = OPC_EXT1;
                default: opc = 7'(rand_bits(7));
            endcase
            if (rand_bits(2) == 0) idle(1 + rand_bits(1));
            send(rand_instr(opc, 3'(rand_bits(3))));
        end
        end_test("6 flow control and ordering");

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// Testbench clock and reset generator
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 4; // 8 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a falling edge, after five rising edges
    initial begin
        rst_n = 1'b0;
        #(2 * HALF_PERIOD * RESET_CYCLES);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* rvdec_top.sv */
// Decode stage top level with decoder, output buffer and scheduler notice
`default_nettype none

module rvdec_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   fetch_valid,
    output logic                  fetch_ready,
    input  wire rvdec_pkg::fetch_t   fetch,
    output logic                  decode_valid,
    input  wire                   decode_ready,
    output rvdec_pkg::decode_t    decode,
    output rvdec_pkg::sched_t     sched
);
    import rvdec_pkg::*;

    imm_set_t    imm;
    func_ops_t   ops;
    dec_fields_t fields;
    decode_t     dec_in;
    logic        is_wstall;

    rvdec_imm_gen u_imm_gen (
        .instr (fetch.instr),
        .imm   (imm)
    );

    rvdec_func_map u_func_map (
        .instr (fetch.instr),
        .ops   (ops)
    );

    rvdec_op_decode u_op_decode (
        .instr     (fetch.instr),
        .imm       (imm),
        .ops       (ops),
        .fields    (fields),
        .is_wstall (is_wstall)
    );

    // Tag travels alongside the decoded fields
    assign dec_in = '{uuid: fetch.uuid, wid: fetch.wid, tmask: fetch.tmask,
                      pc: fetch.pc, fields: fields};

    rvdec_skid_buffer u_skid_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec_in),
        .out_valid (decode_valid),
        .out_ready (decode_ready),
        .out_data  (decode)
    );

    assign sched.valid     = fetch_valid && fetch_ready; // One pulse per accepted fetch
    assign sched.wid       = fetch.wid;
    assign sched.is_wstall = is_wstall;

endmodule

`default_nettype wire

/* rvdec_skid_buffer.sv */
// Two-entry valid/ready buffer for decoded instructions
`default_nettype none

module rvdec_skid_buffer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  wire rvdec_pkg::decode_t in_data,
    output logic                 out_valid,
    input  wire                  out_ready,
    output rvdec_pkg::decode_t   out_data
);
    import rvdec_pkg::*;

    decode_t    mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr]; // Output straight from storage
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

`default_nettype wire

/* rvdec_op_decode.sv */
// Main opcode decoder producing decode fields and the warp stall flag
`default_nettype none

module rvdec_op_decode (
    input  wire [31:0]             instr,
    input  wire rvdec_pkg::imm_set_t  imm,
    input  wire rvdec_pkg::func_ops_t ops,
    output rvdec_pkg::dec_fields_t fields,
    output logic                   is_wstall
);
    import rvdec_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic             use_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        fields    = '0; // Unknown opcodes stay all zero
        use_rd    = 1'b0;
        is_wstall = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                fields.op_type = OP_W'(ops.alu_op);
                fields.op_args.alu.xtype = ARITH;
                if (opcode == OPC_OP_IMM) begin
                    fields.op_args.alu.use_imm = 1'b1;
                    fields.op_args.alu.imm = imm.i;
                end else begin
                    fields.rs2 = rs2;
                end
                use_rd     = 1'b1;
                fields.rd  = rd;
                fields.rs1 = rs1;
            end
            OPC_LUI, OPC_AUIPC: begin
                fields.op_type = (opcode == OPC_AUIPC) ? OP_W'(AUIPC) : OP_W'(LUI);
                fields.op_args.alu.xtype   = ARITH;
                fields.op_args.alu.use_pc  = (opcode == OPC_AUIPC);
                fields.op_args.alu.use_imm = 1'b1;
                fields.op_args.alu.imm     = imm.u;
                use_rd    = 1'b1;
                fields.rd = rd;
            end
            OPC_JAL, OPC_JALR: begin
                fields.op_args.alu.xtype   = BRANCH;
                fields.op_args.alu.use_imm = 1'b1;
                if (opcode == OPC_JAL) begin
                    fields.op_type = OP_W'(JAL);
                    fields.op_args.alu.use_pc = 1'b1;
                    fields.op_args.alu.imm    = imm.j;
                end else begin
                    fields.op_type = OP_W'(JALR);
                    fields.op_args.alu.imm = {{(IMM_W-12){instr[31]}}, instr[31:20]};
                    fields.rs1 = rs1;
                end
                use_rd    = 1'b1;
                fields.rd = rd;
                is_wstall = 1'b1;
            end
            OPC_BRANCH: begin
                fields.op_type = OP_W'(ops.br_op);
                fields.op_args.alu.xtype   = BRANCH;
                fields.op_args.alu.use_pc  = 1'b1;
                fields.op_args.alu.use_imm = 1'b1;
                fields.op_args.alu.imm     = imm.b;
                fields.rs1 = rs1;
                fields.rs2 = rs2;
                is_wstall  = 1'b1;
            end
            OPC_LOAD: begin
                fields.ex_type = EX_LSU;
                fields.op_type = {1'b0, funct3};
                fields.op_args.lsu.offset = instr[31:20];
                use_rd     = 1'b1;
                fields.rd  = rd;
                fields.rs1 = rs1;
            end
            OPC_STORE: begin
                fields.ex_type = EX_LSU;
                fields.op_type = {1'b1, funct3};
                fields.op_args.lsu.is_store = 1'b1;
                fields.op_args.lsu.offset   = imm.s[11:0];
                fields.rs1 = rs1;
                fields.rs2 = rs2;
            end
            OPC_FENCE: begin
                fields.ex_type = EX_LSU;
            end
            OPC_SYSTEM: begin
                use_rd    = 1'b1;
                fields.rd = rd;
                if (funct3[1:0] != 2'b00) begin
                    fields.ex_type = EX_SFU;
                    case (funct3[1:0])
                        2'b01:   fields.op_type = OP_W'(CSRRW);
                        2'b10:   fields.op_type = OP_W'(CSRRS);
                        default: fields.op_type = OP_W'(CSRRC);
                    endcase
                    fields.op_args.csr.addr    = instr[31:20];
                    fields.op_args.csr.use_imm = funct3[2];
                    if (funct3[2]) begin
                        fields.op_args.csr.imm = rs1; // zimm sits in the rs1 slot
                    end else begin
                        fields.rs1 = rs1;
                    end
                end else begin
                    // Trap and return ops go to the branch unit with PC + 4
                    fields.op_type = OP_W'(ops.sys_op);
                    fields.op_args.alu.xtype   = BRANCH;
                    fields.op_args.alu.use_pc  = 1'b1;
                    fields.op_args.alu.use_imm = 1'b1;
                    fields.op_args.alu.imm     = IMM_W'(4);
                    is_wstall = 1'b1;
                end
            end
            OPC_EXT1: begin
                if (funct7 == 7'h00 && funct3 < 3'd6) begin
                    fields.ex_type = EX_SFU;
                    fields.rs1     = rs1;
                    is_wstall      = 1'b1;
                    case (funct3)
                        3'h0: fields.op_type = OP_W'(TMC);
                        3'h1: begin
                            fields.op_type = OP_W'(WSPAWN);
                            fields.rs2 = rs2;
                        end
                        3'h2: begin
                            fields.op_type = OP_W'(SPLIT);
                            fields.op_args.wctl.is_neg = rs2[0];
                            use_rd    = 1'b1;
                            fields.rd = rd;
                        end
                        3'h3: fields.op_type = OP_W'(JOIN);
                        3'h4: begin
                            fields.op_type = OP_W'(BAR);
                            fields.rs2 = rs2;
                        end
                        default: begin
                            fields.op_type = OP_W'(PRED);
                            fields.op_args.wctl.is_neg = rd[0];
                            fields.rs2 = rs2;
                        end
                    endcase
                end
            end
            default: ;
        endcase
        fields.wb = use_rd && (fields.rd != '0); // No writes to x0
    end

endmodule

`default_nettype wire

/* rvdec_func_map.sv */
// Funct-field mapping to ALU, branch and system operation codes
`default_nettype none

module rvdec_func_map (
    input  wire [31:0]           instr,
    output rvdec_pkg::func_ops_t ops
);
    import rvdec_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] sys_field;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign sys_field = instr[31:20];

    always_comb begin
        case (funct3)
            3'h0: ops.alu_op = (opcode[5] && funct7[5]) ? SUB : ADD; // SUB only in reg form
            3'h1: ops.alu_op = SLL;
            3'h2: ops.alu_op = SLT;
            3'h3: ops.alu_op = SLTU;
            3'h4: ops.alu_op = XOR;
            3'h5: ops.alu_op = funct7[5] ? SRA : SRL;
            3'h6: ops.alu_op = OR;
            default: ops.alu_op = AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1: ops.br_op = NE;
            3'h4: ops.br_op = LT;
            3'h5: ops.br_op = GE;
            3'h6: ops.br_op = LTU;
            3'h7: ops.br_op = GEU;
            default: ops.br_op = EQ; // Also the unused codes 2 and 3
        endcase
    end

    always_comb begin
        case (sys_field)
            12'h001: ops.sys_op = EBREAK;
            12'h002: ops.sys_op = URET;
            12'h102: ops.sys_op = SRET;
            12'h302: ops.sys_op = MRET;
            default: ops.sys_op = ECALL;
        endcase
    end

endmodule

`default_nettype wire

/* rvdec_imm_gen.sv */
// Immediate extraction for the I, S, B, J and U formats
`default_nettype none

module rvdec_imm_gen (
    input  wire [31:0]          instr,
    output rvdec_pkg::imm_set_t imm
);
    import rvdec_pkg::*;

    logic [2:0]  funct3;
    logic        is_sh;
    logic [11:0] s_raw;
    logic [12:0] b_raw;
    logic [20:0] j_raw;

    assign funct3 = instr[14:12];
    assign is_sh  = (funct3[1:0] == 2'b01); // SLLI / SRLI / SRAI

    assign s_raw = {instr[31:25], instr[11:7]};
    assign b_raw = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_raw = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        if (is_sh) begin
            imm.i = {{(IMM_W-5){1'b0}}, instr[24:20]}; // Shift amount only
        end else begin
            imm.i = {{(IMM_W-12){instr[31]}}, instr[31:20]};
        end
    end

    assign imm.s = {{(IMM_W-12){s_raw[11]}}, s_raw};
    assign imm.b = {{(IMM_W-13){b_raw[12]}}, b_raw};
    assign imm.j = {{(IMM_W-21){j_raw[20]}}, j_raw};
    assign imm.u = {{(IMM_W-32){instr[31]}}, instr[31:12], 12'b0};

endmodule

`default_nettype wire

/* rvdec_pkg.sv */
// Decode-stage widths, opcode constants, operation enums, argument union and stage structs
`default_nettype none

package rvdec_pkg;

    localparam int UUID_W      = 16;
    localparam int NUM_WARPS   = 4;
    localparam int WID_W       = $clog2(NUM_WARPS);
    localparam int NUM_THREADS = 4;
    localparam int PC_W        = 32;
    localparam int IMM_W       = 32;
    localparam int REG_W       = 5;
    localparam int OP_W        = 4;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC_FENCE  = 7'b000_1111;
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;
    localparam logic [6:0] OPC_EXT1   = 7'b000_1011; // custom-0 used for warp control

    typedef enum logic [1:0] {EX_ALU, EX_LSU, EX_SFU} ex_type_e;

    typedef enum logic [1:0] {ARITH, BRANCH} alu_xtype_e;

    typedef enum logic [OP_W-1:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI, AUIPC
    } alu_op_e;

    typedef enum logic [OP_W-1:0] {
        EQ, NE, LT, GE, LTU, GEU, JAL, JALR, ECALL, EBREAK, URET, SRET, MRET
    } br_op_e;

    typedef enum logic [OP_W-1:0] {
        TMC, WSPAWN, SPLIT, JOIN, BAR, PRED, CSRRW, CSRRS, CSRRC
    } sfu_op_e;

    typedef struct packed {
        alu_xtype_e       xtype;
        logic             use_pc;
        logic             use_imm;
        logic [IMM_W-1:0] imm;
    } alu_args_t;

    typedef struct packed {
        logic [22:0] pad;
        logic        is_store;
        logic [11:0] offset;
    } lsu_args_t;

    typedef struct packed {
        logic [17:0] pad;
        logic [11:0] addr;
        logic        use_imm;
        logic [4:0]  imm;
    } csr_args_t;

    typedef struct packed {
        logic [34:0] pad;
        logic        is_neg;
    } wctl_args_t;

    // Read according to ex_type and op_type
    typedef union packed {
        alu_args_t  alu;
        lsu_args_t  lsu;
        csr_args_t  csr;
        wctl_args_t wctl;
    } op_args_u;

    typedef struct packed {
        logic [IMM_W-1:0] i;
        logic [IMM_W-1:0] s;
        logic [IMM_W-1:0] b;
        logic [IMM_W-1:0] j;
        logic [IMM_W-1:0] u;
    } imm_set_t;

    typedef struct packed {
        alu_op_e alu_op;
        br_op_e  br_op;
        br_op_e  sys_op;
    } func_ops_t;

    typedef struct packed {
        logic [UUID_W-1:0]      uuid;
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_W-1:0]        pc;
        logic [31:0]            instr;
    } fetch_t;

    typedef struct packed {
        ex_type_e         ex_type;
        logic [OP_W-1:0]  op_type;
        op_args_u         op_args;
        logic             wb;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
    } dec_fields_t;

    typedef struct packed {
        logic [UUID_W-1:0]      uuid;
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_W-1:0]        pc;
        dec_fields_t            fields;
    } decode_t;

    typedef struct packed {
        logic             valid;
        logic [WID_W-1:0] wid;
        logic             is_wstall;
    } sched_t;

endpackage

`default_nettype wire
